//--- hdl/fp_div_defs.svh
// ------------------
// Field widths, exponent bias and pipeline depth
// for the double-precision divider
// ------------------

`ifndef FP_DIV_DEFS_SVH
`define FP_DIV_DEFS_SVH

// IEEE 754 binary64 fields
`define FP_DIV_EXP_W   11
`define FP_DIV_MANT_W  52
`define FP_DIV_BIAS    1023

// One restoring stage per quotient bit, implicit one included
`define FP_DIV_STEPS   53

// Unpack + division chain + pack
`define FP_DIV_LATENCY 55

`endif

//--- hdl/fp_div_pkg.sv
// ------------------
// Types shared by the divider pipeline
// Operand class, result kind, sideband and pipeline word
// ------------------

`include "fp_div_defs.svh"

package fp_div_pkg;

    // Operand class, denormals are treated as zero
    typedef enum logic [1:0] {
        CLS_ZERO,
        CLS_NORMAL,
        CLS_INF,
        CLS_NAN
    } fp_class_e;

    // How pack forms the final word
    typedef enum logic [1:0] {
        KIND_DIVIDE,
        KIND_NAN,
        KIND_INF,
        KIND_ZERO
    } res_kind_e;

    // Sideband carried unchanged through every division stage
    typedef struct packed {
        logic                          valid;
        res_kind_e                     kind;
        logic                          sign;
        // Biased exponent before normalization
        logic signed [`FP_DIV_EXP_W:0] exp_res;
    } fp_side_t;

    // One word of the division pipeline
    typedef struct packed {
        logic [`FP_DIV_MANT_W+1:0] rem;
        logic [`FP_DIV_MANT_W:0]   dividend;
        logic [`FP_DIV_MANT_W:0]   divisor;
        logic [`FP_DIV_MANT_W:0]   quot;
        fp_side_t                  side;
    } div_word_t;

endpackage

//--- hdl/fp_div_unpack.sv
// ------------------
// Input stage of the divider
// Field split, operand classes, special-case kind,
// sign and exponent, first pipeline word
// ------------------

`timescale 1ns/1ns

`include "fp_div_defs.svh"

module fp_div_unpack (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_valid,
    input  logic [63:0]           a,
    input  logic [63:0]           b,
    output fp_div_pkg::div_word_t word_out
);
    import fp_div_pkg::*;

    localparam int EXP_MAX = (1 << `FP_DIV_EXP_W) - 1;

    function automatic fp_class_e classify(
        input logic [`FP_DIV_EXP_W-1:0]  e,
        input logic [`FP_DIV_MANT_W-1:0] m
    );
        fp_class_e cls;
        if (e == '0) begin
            // Denormals flushed to zero
            cls = CLS_ZERO;
        end else if (e == EXP_MAX[`FP_DIV_EXP_W-1:0]) begin
            cls = (m != '0) ? CLS_NAN : CLS_INF;
        end else begin
            cls = CLS_NORMAL;
        end
        return cls;
    endfunction

    logic                            sign_a;
    logic                            sign_b;
    logic [`FP_DIV_EXP_W-1:0]        exp_a;
    logic [`FP_DIV_EXP_W-1:0]        exp_b;
    logic [`FP_DIV_MANT_W-1:0]       man_a;
    logic [`FP_DIV_MANT_W-1:0]       man_b;
    fp_class_e                       cls_a;
    fp_class_e                       cls_b;
    logic [`FP_DIV_MANT_W:0]         full_a;
    logic [`FP_DIV_MANT_W:0]         full_b;
    logic signed [`FP_DIV_EXP_W+1:0] exp_wide;
    res_kind_e                       kind;

    // Registered pipeline word
    logic [`FP_DIV_MANT_W+1:0]       rem_q;
    logic [`FP_DIV_MANT_W:0]         dividend_q;
    logic [`FP_DIV_MANT_W:0]         divisor_q;
    fp_side_t                        side_q;

    always_comb begin
        {sign_a, exp_a, man_a} = a;
        {sign_b, exp_b, man_b} = b;
        cls_a  = classify(exp_a, man_a);
        cls_b  = classify(exp_b, man_b);
        full_a = {(cls_a == CLS_NORMAL), man_a};
        full_b = {(cls_b == CLS_NORMAL), man_b};

        // One bit wider than the sideband so overflow is caught here
        exp_wide = $signed({2'b00, exp_a}) - $signed({2'b00, exp_b})
                 + $signed((`FP_DIV_EXP_W+2)'(`FP_DIV_BIAS));

        // NaN first, then infinity, then zero
        if (cls_a == CLS_NAN || cls_b == CLS_NAN ||
            (cls_a == CLS_INF && cls_b == CLS_INF) ||
            (cls_a == CLS_ZERO && cls_b == CLS_ZERO)) begin
            kind = KIND_NAN;
        end else if (cls_a == CLS_INF || cls_b == CLS_ZERO) begin
            kind = KIND_INF;
        end else if (cls_a == CLS_ZERO || cls_b == CLS_INF) begin
            kind = KIND_ZERO;
        end else if (exp_wide > EXP_MAX) begin
            // Too large even after the normalize decrement
            kind = KIND_INF;
        end else begin
            kind = KIND_DIVIDE;
        end
    end

    // The first 52 steps of the long division only move the upper
    // mantissa bits into the remainder, so they start there and the
    // dividend keeps the low bit followed by the fraction zeros
    always_ff @(posedge clk) begin
        rem_q      <= {2'b00, full_a[`FP_DIV_MANT_W:1]};
        dividend_q <= {full_a[0], {`FP_DIV_MANT_W{1'b0}}};
        divisor_q  <= full_b;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            side_q <= '0;
        end else begin
            side_q.valid   <= in_valid;
            side_q.kind    <= kind;
            side_q.sign    <= sign_a ^ sign_b;
            side_q.exp_res <= exp_wide[`FP_DIV_EXP_W:0];
        end
    end

    assign word_out = '{rem:      rem_q,
                        dividend: dividend_q,
                        divisor:  divisor_q,
                        quot:     '0,
                        side:     side_q};

endmodule

//--- hdl/fp_div_step.sv
// ------------------
// One restoring-division stage
// Produces one quotient bit per cycle
// ------------------

`timescale 1ns/1ns

`include "fp_div_defs.svh"

module fp_div_step (
    input  logic                  clk,
    input  logic                  rst_n,
    input  fp_div_pkg::div_word_t word_in,
    output fp_div_pkg::div_word_t word_out
);
    import fp_div_pkg::*;

    logic [`FP_DIV_MANT_W+1:0] shifted_rem;
    // One extra bit holds the sign of the trial subtraction
    logic [`FP_DIV_MANT_W+2:0] trial;
    logic                      q_bit;

    logic [`FP_DIV_MANT_W+1:0] rem_q;
    logic [`FP_DIV_MANT_W:0]   dividend_q;
    logic [`FP_DIV_MANT_W:0]   divisor_q;
    logic [`FP_DIV_MANT_W:0]   quot_q;
    fp_side_t                  side_q;

    // --------------------
    // Trial subtraction
    // --------------------
    always_comb begin
        shifted_rem = {word_in.rem[`FP_DIV_MANT_W:0],
                       word_in.dividend[`FP_DIV_MANT_W]};
        trial       = {1'b0, shifted_rem} - {2'b00, word_in.divisor};
        q_bit       = ~trial[`FP_DIV_MANT_W+2];
    end

    // --------------------
    // Stage registers
    // --------------------
    always_ff @(posedge clk) begin
        // Restore by keeping the shifted remainder when the trial went negative
        rem_q      <= q_bit ? trial[`FP_DIV_MANT_W+1:0] : shifted_rem;
        dividend_q <= {word_in.dividend[`FP_DIV_MANT_W-1:0], 1'b0};
        divisor_q  <= word_in.divisor;
        quot_q     <= {word_in.quot[`FP_DIV_MANT_W-1:0], q_bit};
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            side_q <= '0;
        end else begin
            side_q <= word_in.side;
        end
    end

    assign word_out = '{rem:      rem_q,
                        dividend: dividend_q,
                        divisor:  divisor_q,
                        quot:     quot_q,
                        side:     side_q};

endmodule

//--- hdl/fp_div_pack.sv
// ------------------
// Output stage of the divider
// Normalize, overflow and underflow,
// special results, registered output
// ------------------

`timescale 1ns/1ns

`include "fp_div_defs.svh"

module fp_div_pack (
    input  logic                  clk,
    input  logic                  rst_n,
    input  fp_div_pkg::div_word_t word_in,
    output logic                  out_valid,
    output logic [63:0]           result
);
    import fp_div_pkg::*;

    localparam int          EXP_MAX = (1 << `FP_DIV_EXP_W) - 1;
    localparam logic [63:0] QNAN    = 64'h7FF8_0000_0000_0000;

    fp_side_t                        side;
    logic [`FP_DIV_MANT_W:0]         quot;
    logic signed [`FP_DIV_EXP_W:0]   norm_exp;
    logic [`FP_DIV_MANT_W-1:0]       norm_mant;
    logic [`FP_DIV_EXP_W:0]          shift_amt;
    logic [`FP_DIV_MANT_W:0]         den_mant;
    logic [`FP_DIV_EXP_W-1:0]        out_exp;
    logic [`FP_DIV_MANT_W-1:0]       out_mant;
    logic [63:0]                     packed_word;

    // --------------------
    // Normalize
    // --------------------
    always_comb begin
        side = word_in.side;
        quot = word_in.quot;

        if (quot[`FP_DIV_MANT_W]) begin
            norm_exp  = side.exp_res;
            norm_mant = quot[`FP_DIV_MANT_W-1:0];
        end else begin
            // Ratio below one puts the leading one a place lower
            norm_exp  = side.exp_res - $signed((`FP_DIV_EXP_W+1)'(1));
            norm_mant = {quot[`FP_DIV_MANT_W-2:0], 1'b0};
        end
    end

    // --------------------
    // Overflow and underflow
    // --------------------
    always_comb begin
        shift_amt = 1 - norm_exp;
        den_mant  = {1'b1, norm_mant} >> shift_amt;
        out_exp   = norm_exp[`FP_DIV_EXP_W-1:0];
        out_mant  = norm_mant;

        if (norm_exp >= EXP_MAX) begin
            out_exp  = '1;
            out_mant = '0;
        end else if (norm_exp <= 0) begin
            // Denormal result
            // A shift past every bit leaves a signed zero
            out_exp  = '0;
            out_mant = den_mant[`FP_DIV_MANT_W-1:0];
        end
    end

    // Special kinds bypass the quotient
    always_comb begin
        case (side.kind)
            KIND_NAN: begin
                packed_word = QNAN;
            end
            KIND_INF: begin
                packed_word = {side.sign, {`FP_DIV_EXP_W{1'b1}}, {`FP_DIV_MANT_W{1'b0}}};
            end
            KIND_ZERO: begin
                packed_word = {side.sign, 63'b0};
            end
            default: begin
                packed_word = {side.sign, out_exp, out_mant};
            end
        endcase
    end

    // --------------------
    // Output registers
    // --------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            result    <= '0;
        end else begin
            out_valid <= side.valid;
            result    <= packed_word;
        end
    end

endmodule

//--- hdl/fp_div_top.sv
// ------------------
// Pipelined double-precision divider
// Unpack, 53 division stages, pack
// ------------------

`timescale 1ns/1ns

`include "fp_div_defs.svh"

module fp_div_top (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        in_valid,
    input  logic [63:0] a,
    input  logic [63:0] b,
    output logic        out_valid,
    output logic [63:0] result
);
    import fp_div_pkg::*;

    // Entry k feeds stage k, the last entry feeds pack
    div_word_t stage_word [0:`FP_DIV_STEPS];

    // --------------------
    // Input stage
    // --------------------
    fp_div_unpack i_unpack (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .a        (a),
        .b        (b),
        .word_out (stage_word[0])
    );

    // --------------------
    // Division chain
    // --------------------
    for (genvar k = 0; k < `FP_DIV_STEPS; k++) begin : g_step
        fp_div_step i_step (
            .clk      (clk),
            .rst_n    (rst_n),
            .word_in  (stage_word[k]),
            .word_out (stage_word[k+1])
        );
    end

    // --------------------
    // Output stage
    // --------------------
    fp_div_pack i_pack (
        .clk       (clk),
        .rst_n     (rst_n),
        .word_in   (stage_word[`FP_DIV_STEPS]),
        .out_valid (out_valid),
        .result    (result)
    );

endmodule

//--- dv/fp_div_clkgen.sv
// --------------------
// Testbench clock (8 ns period) and reset pulse
// --------------------

`timescale 1ns/1ns

module fp_div_clkgen (
    output logic clk,
    output logic rst_n
);
    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;
        // Reset held over the first two rising edges
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
    end

    always #4 clk = ~clk;

endmodule

//--- dv/fp_div_asserts.sv
// --------------------
// Concurrent checks on the divider top level
// Fixed latency, known result, reset behavior
// --------------------

`timescale 1ns/1ns

`include "fp_div_defs.svh"

module fp_div_asserts (
    input logic        clk,
    input logic        rst_n,
    input logic        in_valid,
    input logic        out_valid,
    input logic [63:0] result
);
    int fail_count = 0;

    // Every strobe gives exactly one output pulse, LATENCY cycles on
    a_strobe_out: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid |-> ##(`FP_DIV_LATENCY) out_valid)
        else begin
            $error("out_valid missing after an input strobe");
            fail_count++;
        end

    a_idle_out: assert property (@(posedge clk) disable iff (!rst_n)
        !in_valid |-> ##(`FP_DIV_LATENCY) !out_valid)
        else begin
            $error("out_valid raised without a matching input strobe");
            fail_count++;
        end

    a_known: assert property (@(posedge clk) out_valid |-> !$isunknown(result))
        else begin
            $error("result has unknown bits while out_valid is high");
            fail_count++;
        end

    // Synchronous reset clears out_valid on the following edge
    a_reset: assert property (@(posedge clk) !rst_n |=> !out_valid)
        else begin
            $error("out_valid high during reset");
            fail_count++;
        end

endmodule

//--- dv/fp_div_model.svh
// --------------------
// Reference quotient for the divider
// Operand class and Galois LFSR step
// --------------------

`ifndef FP_DIV_MODEL_SVH
`define FP_DIV_MODEL_SVH

    function automatic fp_class_e operand_class(input logic [63:0] x);
        if (x[62:52] == 11'h000) begin
            return CLS_ZERO;
        end else if (x[62:52] == 11'h7FF) begin
            return (x[51:0] != 52'h0) ? CLS_NAN : CLS_INF;
        end
        return CLS_NORMAL;
    endfunction

    // Truncated quotient, one normalize place, saturate and denormalize
    function automatic logic [63:0] fp_div_expected(input logic [63:0] x, input logic [63:0] y);
        fp_class_e    ca;
        fp_class_e    cb;
        logic         sign;
        int           e;
        logic [104:0] num;
        logic [52:0]  q;
        logic [52:0]  den;
        ca   = operand_class(x);
        cb   = operand_class(y);
        sign = x[63] ^ y[63];
        if (ca == CLS_NAN || cb == CLS_NAN || (ca == CLS_INF && cb == CLS_INF) ||
            (ca == CLS_ZERO && cb == CLS_ZERO)) begin
            return 64'h7FF8_0000_0000_0000;
        end
        if (ca == CLS_INF || cb == CLS_ZERO) begin
            return {sign, 11'h7FF, 52'h0};
        end
        if (ca == CLS_ZERO || cb == CLS_INF) begin
            return {sign, 63'h0};
        end
        e   = int'(x[62:52]) - int'(y[62:52]) + 1023;
        num = {1'b1, x[51:0], 52'h0};
        q   = 53'(num / {52'h0, 1'b1, y[51:0]});
        if (!q[52]) begin
            q = q << 1;
            e = e - 1;
        end
        if (e >= 2047) begin
            return {sign, 11'h7FF, 52'h0};
        end
        if (e <= 0) begin
            den = (1 - e > 53) ? 53'h0 : q >> (1 - e);
            return {sign, 11'h000, den[51:0]};
        end
        return {sign, e[10:0], q[51:0]};
    endfunction

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8000_0057) : (s >> 1);
    endfunction

`endif

//--- dv/fp_div_tb.sv
// --------------------
// Testbench for the pipelined double divider
// Directed, special, range, random and sparse tests,
// scoreboard queue, compare process and watchdog
// --------------------

`timescale 1ns/1ns

`include "fp_div_defs.svh"

module fp_div_tb;
    import fp_div_pkg::*;

    `include "fp_div_model.svh"

    localparam int LAT      = `FP_DIV_LATENCY;
    localparam int CLK_NS   = 8;
    localparam int RANDOM_N = 400;
    localparam int SPARSE_N = 120;
    // Directed slots, strobe slots with gaps, one drain per test, margin
    localparam int BUDGET_CYCLES = 2 + 48 + RANDOM_N + SPARSE_N * 8 + 6 * (LAT + 2) + 100;

    logic        clk;
    logic        rst_n;
    logic        in_valid;
    logic [63:0] a;
    logic [63:0] b;
    logic        out_valid;
    logic [63:0] result;
    logic [31:0] lfsr;
    int          cyc;
    int          n_strobes;
    int          n_out;
    int          pass_count;
    int          err_count;
    int          mark_ops;
    int          mark_out;
    int          mark_err;

    // Scoreboard of expected word, driving edge and operand text per strobe
    logic [63:0] exp_q [$];
    int          drive_edge_q [$];
    string       msg_q [$];

    fp_div_clkgen i_clkgen (.clk(clk), .rst_n(rst_n));

    fp_div_top i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .a         (a),
        .b         (b),
        .out_valid (out_valid),
        .result    (result)
    );

    bind fp_div_top fp_div_asserts i_asserts (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .out_valid (out_valid),
        .result    (result)
    );

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    task automatic check_value(input logic [63:0] got, input logic [63:0] expected,
                               input string what);
        if (got !== expected) begin
            $display("ERR %0t ns: %s, got %h expected %h", $time, what, got, expected);
            err_count++;
        end else begin
            pass_count++;
        end
    endtask

    // --------------------
    // Compare process
    // --------------------
    always @(negedge clk) begin
        string msg;
        if (out_valid === 1'b1) begin
            n_out++;
            if (exp_q.size() == 0) begin
                $display("Output pulse at %0t ns with no operation in flight", $time);
                err_count++;
            end else begin
                msg = msg_q.pop_front();
                check_value(result, exp_q.pop_front(), {msg, " result"});
                check_value(64'(cyc - drive_edge_q.pop_front()), 64'(LAT), {msg, " latency"});
            end
        end
    end

    task automatic drive_pair(input logic [63:0] x, input logic [63:0] y);
        @(posedge clk);
        in_valid <= 1'b1;
        a        <= x;
        b        <= y;
        exp_q.push_back(fp_div_expected(x, y));
        // Index of the current edge since the counter steps after it
        drive_edge_q.push_back(cyc + 1);
        msg_q.push_back($sformatf("%h / %h", x, y));
        n_strobes++;
    endtask

    task automatic drive_idle();
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic random_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[62:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    // Exponent kept within 512..1535 so most quotients stay normal
    task automatic random_normal(output logic [63:0] x);
        logic [63:0] s;
        logic [63:0] e;
        logic [63:0] m;
        random_bits(1, s);
        random_bits(10, e);
        random_bits(52, m);
        x = {s[0], 11'(512 + e[9:0]), m[51:0]};
    endtask

    task automatic drain_and_report(input string name);
        drive_idle();
        // The last result is due LAT edges after the final strobe
        for (int i = 0; i < LAT + 2 && exp_q.size() != 0; i++) begin
            @(negedge clk);
        end
        @(negedge clk);
        check_value(64'(n_out - mark_out), 64'(n_strobes - mark_ops), {name, " pulse count"});
        $display("%s: %0d operations, %0d errors", name, n_strobes - mark_ops,
                 err_count - mark_err);
        mark_ops = n_strobes;
        mark_out = n_out;
        mark_err = err_count;
    endtask

    // --------------------
    // Tests
    // --------------------
    task automatic normal_quotients();
        drive_pair(64'h4018_0000_0000_0000, 64'h4008_0000_0000_0000);
        drive_pair(64'h3FF0_0000_0000_0000, 64'h4008_0000_0000_0000);
        drive_pair(64'hC018_0000_0000_0000, 64'h4008_0000_0000_0000);
        drive_pair(64'h4024_0000_0000_0000, 64'hC01C_0000_0000_0000);
        // Mantissa ratio below one
        drive_pair(64'h3FF0_0000_0000_0000, 64'h3FF8_0000_0000_0000);
        drive_pair(64'h4008_0000_0000_0000, 64'h401C_0000_0000_0000);
        drain_and_report("normal quotients");
    endtask

    task automatic special_operands();
        drive_pair(64'h7FF8_0000_0000_0000, 64'h4008_0000_0000_0000);
        drive_pair(64'h0000_0000_0000_0000, 64'h7FF0_0000_0000_0001);
        drive_pair(64'h7FF8_0000_0000_0000, 64'h7FF0_0000_0000_0000);
        drive_pair(64'h7FF0_0000_0000_0000, 64'hFFF0_0000_0000_0000);
        drive_pair(64'h0000_0000_0000_0000, 64'h8000_0000_0000_0000);
        drive_pair(64'h4008_0000_0000_0000, 64'h0000_0000_0000_0000);
        drive_pair(64'hC008_0000_0000_0000, 64'h0000_0000_0000_0000);
        drive_pair(64'h0000_0000_0000_0000, 64'h4008_0000_0000_0000);
        drive_pair(64'h8000_0000_0000_0000, 64'h4008_0000_0000_0000);
        drive_pair(64'h4008_0000_0000_0000, 64'h7FF0_0000_0000_0000);
        drive_pair(64'h4008_0000_0000_0000, 64'hFFF0_0000_0000_0000);
        drive_pair(64'h7FF0_0000_0000_0000, 64'h4008_0000_0000_0000);
        drive_pair(64'hFFF0_0000_0000_0000, 64'hC008_0000_0000_0000);
        // Denormal operands count as zero
        drive_pair(64'h0000_0000_0000_0001, 64'h4008_0000_0000_0000);
        drive_pair(64'h4008_0000_0000_0000, 64'h800F_FFFF_FFFF_FFFF);
        drive_pair(64'h0008_0000_0000_0000, 64'h0000_0000_0000_0001);
        drain_and_report("special operands");
    endtask

    task automatic range_limits();
        drive_pair(64'h7FEF_FFFF_FFFF_FFFF, 64'h0010_0000_0000_0000);
        drive_pair(64'hFFE0_0000_0000_0000, 64'h3FE0_0000_0000_0000);
        drive_pair(64'h0010_0000_0000_0000, 64'h4010_0000_0000_0000);
        drive_pair(64'h801F_FFFF_FFFF_FFFF, 64'h4000_0000_0000_0000);
        drive_pair(64'h0010_0000_0000_0000, 64'h7FEF_FFFF_FFFF_FFFF);
        drive_pair(64'h0030_0000_0000_0000, 64'h4350_0000_0000_0000);
        drain_and_report("overflow and underflow");
    endtask

    task automatic random_stream();
        logic [63:0] x;
        logic [63:0] y;
        for (int i = 0; i < RANDOM_N; i++) begin
            random_normal(x);
            random_normal(y);
            drive_pair(x, y);
        end
        drain_and_report("random stream");
    endtask

    task automatic sparse_strobes();
        logic [63:0] x;
        logic [63:0] y;
        logic [63:0] gap;
        for (int i = 0; i < SPARSE_N; i++) begin
            random_normal(x);
            random_normal(y);
            drive_pair(x, y);
            random_bits(3, gap);
            repeat (gap[2:0]) drive_idle();
        end
        drain_and_report("sparse strobes");
    endtask

    initial begin
        in_valid = 1'b0;
        a        = '0;
        b        = '0;
        lfsr     = 32'h2b6c_6164;
        while (rst_n !== 1'b1) begin
            @(posedge clk);
        end
        normal_quotients();
        special_operands();
        range_limits();
        random_stream();
        sparse_strobes();
        repeat (LAT + 5) @(negedge clk);
        if (exp_q.size() != 0) begin
            $display("%0d results never came out of the pipeline", exp_q.size());
            err_count++;
        end
        check_value(64'(n_out), 64'(n_strobes), "total output pulses");
        if (i_dut.i_asserts.fail_count != 0) begin
            $display("%0d assertion failures", i_dut.i_asserts.fail_count);
            err_count++;
        end
        $display("checks passed %0d, errors %0d", pass_count, err_count);
        if (err_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(BUDGET_CYCLES * CLK_NS);
        $display("Run did not finish within %0d cycles", BUDGET_CYCLES);
        $display("Test failed");
        $finish;
    end

endmodule

//--- fp_div.f
+incdir+hdl
+incdir+dv
hdl/fp_div_pkg.sv
hdl/fp_div_unpack.sv
hdl/fp_div_step.sv
hdl/fp_div_pack.sv
hdl/fp_div_top.sv
dv/fp_div_clkgen.sv
dv/fp_div_asserts.sv
dv/fp_div_tb.sv

//--- Makefile
TOP := fp_div_tb

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP) +verilator+error+limit+1000); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test completed successfully"

obj_dir/V$(TOP): fp_div.f $(wildcard hdl/*.sv hdl/*.svh dv/*.sv dv/*.svh)
	verilator --binary --timing --assert -Wno-fatal -f fp_div.f --top-module $(TOP)

lint:
	verilator --lint-only --timing -Wall -f fp_div.f --top-module $(TOP)

clean:
	rm -rf obj_dir
